//--- include/tpu_defines.svh
`ifndef TPU_DEFINES_SVH
`define TPU_DEFINES_SVH

// Systolic array geometry, PEs per row and per column
`define TPU_ARRAY_DIM 4

// Datapath widths
`define TPU_OPERAND_W 8
`define TPU_ACC_W     32

// Memory index width, shared by A, B and C
`define TPU_INDEX_W   16

// Width of the K, M and N fields
`define TPU_DIM_W     8

`endif

//--- hdl/tpu_data_pkg.sv
`include "tpu_defines.svh"

package tpu_data_pkg;

    // Single unsigned operand byte
    typedef logic [`TPU_OPERAND_W-1:0] operand_t;

    // Accumulator, wraps modulo 2^32
    typedef logic [`TPU_ACC_W-1:0] acc_t;

    // One operand per array row or column
    // Lane 0 sits in the top byte, so index 0 is the MSB end
    typedef operand_t [0:`TPU_ARRAY_DIM-1] lane_vec_t;

    // One full row of accumulators, the C memory word
    // Lane 0 again in the top bits
    typedef acc_t [0:`TPU_ARRAY_DIM-1] result_row_t;

endpackage

//--- hdl/tpu_ctrl_pkg.sv
`include "tpu_defines.svh"

package tpu_ctrl_pkg;

    // Controller states, one run walks idle -> (calc -> done)* -> idle
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_CALC = 2'd1,
        ST_DONE = 2'd2
    } tpu_state_t;

    // Matrix dimensions of one job
    // M and N are multiples of 4
    typedef struct packed {
        logic [`TPU_DIM_W-1:0] k;
        logic [`TPU_DIM_W-1:0] m;
        logic [`TPU_DIM_W-1:0] n;
    } mat_dims_t;

    // Read index into the A or B memory
    typedef logic [`TPU_INDEX_W-1:0] rd_req_t;

    // Write request to the C memory, one result row per cycle
    typedef struct packed {
        logic                      wr_en;
        logic [`TPU_INDEX_W-1:0]   index;
        tpu_data_pkg::result_row_t data;
    } c_wr_t;

endpackage

//--- hdl/tpu_pe.sv
`timescale 1ns/1ps
`include "tpu_defines.svh"

module tpu_pe (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  tpu_data_pkg::operand_t north,
    input  tpu_data_pkg::operand_t west,
    output tpu_data_pkg::operand_t south,
    output tpu_data_pkg::operand_t east,
    output tpu_data_pkg::acc_t     acc
);
    import tpu_data_pkg::*;

    logic [2*`TPU_OPERAND_W-1:0] mac_prod;
    acc_t                        acc_q;

    assign mac_prod = north * west;

    // Running sum including the product of this cycle, so the last
    // operand pair of a tile is visible in the same cycle it arrives
    assign acc = acc_q + acc_t'(mac_prod);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
            south <= '0;
            east  <= '0;
        end else begin
            south <= north;
            east  <= west;
            if (flush) begin
                acc_q <= '0;
            end else begin
                acc_q <= acc;
            end
        end
    end

endmodule

//--- hdl/tpu_skew_buffer.sv
`timescale 1ns/1ps
`include "tpu_defines.svh"

module tpu_skew_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load,
    input  logic                    clear,
    input  tpu_data_pkg::lane_vec_t word,
    output tpu_data_pkg::lane_vec_t edge_out
);
    import tpu_data_pkg::*;

    localparam int DIM = `TPU_ARRAY_DIM;

    lane_vec_t lane_in;

    // Zeros flow in whenever no word is being loaded
    assign lane_in = load ? word : '0;

    // Lane i is i+1 stages deep, giving the diagonal wavefront
    for (genvar i = 0; i < DIM; i++) begin : g_lane
        operand_t stage [0:i];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int s = 0; s <= i; s++) begin
                    stage[s] <= '0;
                end
            end else if (clear) begin
                for (int s = 0; s <= i; s++) begin
                    stage[s] <= '0;
                end
            end else begin
                stage[0] <= lane_in[i];
                for (int s = 1; s <= i; s++) begin
                    stage[s] <= stage[s-1];
                end
            end
        end

        assign edge_out[i] = stage[i];
    end

    // Controller must never load and empty the buffer in one cycle
    a_load_clear_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load && clear)
    ) else $error("skew buffer got load and clear together");

endmodule

//--- hdl/tpu_pe_array.sv
`timescale 1ns/1ps
`include "tpu_defines.svh"

module tpu_pe_array (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,
    input  tpu_data_pkg::lane_vec_t   west,
    input  tpu_data_pkg::lane_vec_t   north,
    input  logic [1:0]                row_sel,
    output tpu_data_pkg::result_row_t row_out
);
    import tpu_data_pkg::*;

    localparam int DIM = `TPU_ARRAY_DIM;

    // Links between neighbours, index 0 is the array edge
    // The links past the last column and row end at the border
    operand_t h_link   [DIM][DIM+1];
    operand_t v_link   [DIM+1][DIM];
    acc_t     acc_grid [DIM][DIM];

    for (genvar r = 0; r < DIM; r++) begin : g_row
        assign h_link[r][0] = west[r];
        assign v_link[0][r] = north[r];

        for (genvar c = 0; c < DIM; c++) begin : g_col
            tpu_pe u_pe (
                .clk   (clk),
                .rst_n (rst_n),
                .flush (flush),
                .north (v_link[r][c]),
                .west  (h_link[r][c]),
                .south (v_link[r+1][c]),
                .east  (h_link[r][c+1]),
                .acc   (acc_grid[r][c])
            );
        end
    end

    // Pack the selected row for write-back, column 0 in the top bits
    always_comb begin
        for (int c = 0; c < DIM; c++) begin
            row_out[c] = acc_grid[row_sel][c];
        end
    end

endmodule

//--- hdl/tpu_controller.sv
`timescale 1ns/1ps
`include "tpu_defines.svh"

module tpu_controller (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  tpu_ctrl_pkg::mat_dims_t dims,
    output logic                    busy,
    output tpu_ctrl_pkg::rd_req_t   a_index,
    output tpu_ctrl_pkg::rd_req_t   b_index,
    output logic                    load,
    output logic                    clear,
    output logic                    flush,
    output logic [1:0]              row_sel,
    output logic                    c_wr_en,
    output logic [`TPU_INDEX_W-1:0] c_index
);
    import tpu_ctrl_pkg::*;

    localparam int DIM_W = `TPU_DIM_W;
    localparam int CNT_W = `TPU_DIM_W + 1;

    tpu_state_t              state;
    tpu_state_t              state_next;
    mat_dims_t               dims_q;
    logic [CNT_W-1:0]        calc_cnt;
    logic [DIM_W-1:0]        mb;
    logic [DIM_W-1:0]        nb;
    logic [`TPU_INDEX_W-1:0] c_cnt;
    logic                    issue;
    logic                    calc_last;
    logic                    done_last;
    logic                    last_tile;

    // -------------------------------------------------
    // Tile bookkeeping
    // -------------------------------------------------

    // K issue cycles plus 4 for the skew to drain through the array
    assign calc_last = (state == ST_CALC)
                     && (calc_cnt == {1'b0, dims_q.k} + CNT_W'(3));
    assign done_last = (state == ST_DONE) && (c_cnt[1:0] == 2'd3);
    assign last_tile = (mb == (dims_q.m >> 2) - DIM_W'(1))
                    && (nb == (dims_q.n >> 2) - DIM_W'(1));
    assign issue     = (state == ST_CALC) && (calc_cnt < {1'b0, dims_q.k});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dims_q <= '0;
        end else if (state == ST_IDLE && in_valid) begin
            dims_q <= dims;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            calc_cnt <= '0;
        end else if (state == ST_CALC && !calc_last) begin
            calc_cnt <= calc_cnt + CNT_W'(1);
        end else begin
            calc_cnt <= '0;
        end
    end

    // M block is the inner loop, N block the outer one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mb <= '0;
            nb <= '0;
        end else if (state == ST_IDLE) begin
            mb <= '0;
            nb <= '0;
        end else if (done_last) begin
            if (mb == (dims_q.m >> 2) - DIM_W'(1)) begin
                mb <= '0;
                nb <= nb + DIM_W'(1);
            end else begin
                mb <= mb + DIM_W'(1);
            end
        end
    end

    // C word counter, tiles write 4 rows each so the low bits give the row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_cnt <= '0;
        end else if (state == ST_IDLE) begin
            c_cnt <= '0;
        end else if (state == ST_DONE) begin
            c_cnt <= c_cnt + 1'b1;
        end
    end

    // -------------------------------------------------
    // FSM
    // -------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: if (in_valid) state_next = ST_CALC;
            ST_CALC: if (calc_last) state_next = ST_DONE;
            ST_DONE: if (done_last) state_next = last_tile ? ST_IDLE : ST_CALC;
            default: state_next = ST_IDLE;
        endcase
    end

    // Memory data comes back one cycle after the index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load <= 1'b0;
        end else begin
            load <= issue;
        end
    end

    // -------------------------------------------------
    // Outputs
    // -------------------------------------------------

    assign a_index = issue ? rd_req_t'(mb) * rd_req_t'(dims_q.k) + rd_req_t'(calc_cnt)
                           : rd_req_t'(mb) * rd_req_t'(dims_q.k);
    assign b_index = issue ? rd_req_t'(nb) * rd_req_t'(dims_q.k) + rd_req_t'(calc_cnt)
                           : rd_req_t'(nb) * rd_req_t'(dims_q.k);

    assign busy    = (state != ST_IDLE);
    assign clear   = (state != ST_CALC);
    assign flush   = done_last;
    assign c_wr_en = (state == ST_DONE);
    assign c_index = c_cnt;
    assign row_sel = c_cnt[1:0];

    // A write burst always opens at row 0 of a tile
    a_burst_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(c_wr_en) |-> (row_sel == 2'd0)
    ) else $error("C write burst started outside a tile boundary");

    // Write-back never runs past the last word of the result image
    a_c_index_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        c_wr_en |-> (int'(c_index) < (int'(dims_q.m) * int'(dims_q.n)) / 4)
    ) else $error("C write index beyond the result matrix");

endmodule

//--- hdl/tpu_top.sv
`timescale 1ns/1ps
`include "tpu_defines.svh"

module tpu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  tpu_ctrl_pkg::mat_dims_t dims,
    output logic                    busy,
    output tpu_ctrl_pkg::rd_req_t   a_index,
    input  tpu_data_pkg::lane_vec_t a_rdata,
    output tpu_ctrl_pkg::rd_req_t   b_index,
    input  tpu_data_pkg::lane_vec_t b_rdata,
    output tpu_ctrl_pkg::c_wr_t     c_wr
);
    import tpu_data_pkg::*;

    logic                    load;
    logic                    clear;
    logic                    flush;
    logic [1:0]              row_sel;
    logic                    c_wr_en;
    logic [`TPU_INDEX_W-1:0] c_index;
    lane_vec_t               west_edge;
    lane_vec_t               north_edge;
    result_row_t             row_out;

    tpu_controller u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .dims     (dims),
        .busy     (busy),
        .a_index  (a_index),
        .b_index  (b_index),
        .load     (load),
        .clear    (clear),
        .flush    (flush),
        .row_sel  (row_sel),
        .c_wr_en  (c_wr_en),
        .c_index  (c_index)
    );

    // Rows of A enter from the west
    tpu_skew_buffer skew_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .clear    (clear),
        .word     (a_rdata),
        .edge_out (west_edge)
    );

    // Columns of B enter from the north
    tpu_skew_buffer skew_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .clear    (clear),
        .word     (b_rdata),
        .edge_out (north_edge)
    );

    tpu_pe_array u_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .west    (west_edge),
        .north   (north_edge),
        .row_sel (row_sel),
        .row_out (row_out)
    );

    assign c_wr = '{wr_en: c_wr_en, index: c_index, data: row_out};

endmodule

//--- verification/tpu_checker.sv
`timescale 1ns/1ps
`include "tpu_defines.svh"

module tpu_checker #(
    parameter int MAX_C = 1024
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic                      busy,
    input  tpu_ctrl_pkg::mat_dims_t   dims,
    input  tpu_ctrl_pkg::rd_req_t     a_index,
    input  tpu_ctrl_pkg::rd_req_t     b_index,
    input  tpu_ctrl_pkg::c_wr_t       c_wr,
    input  tpu_data_pkg::result_row_t exp_words [MAX_C],
    input  int                        exp_count,
    input  int                        test_num,
    input  logic                      test_end,
    output int                        error_count,
    output int                        tests_passed,
    output int                        tests_failed
);
    import tpu_data_pkg::*;
    import tpu_ctrl_pkg::*;

    logic seen [MAX_C];
    logic busy_q;
    logic in_valid_q;
    int   run_len;
    int   test_errs;
    int   words;

    initial begin
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_errs    = 0;
        words        = 0;
        for (int i = 0; i < MAX_C; i++)
            seen[i] = 1'b0;
    end

    task automatic flag_error();
        test_errs++;
        error_count++;
    endtask

    task automatic check_write();
        int idx;
        idx = int'(c_wr.index);
        if (!busy) begin
            $display("C write to index %0d at %0t while busy is low", idx, $time);
            flag_error();
        end
        if (run_len == 0 && idx % 4 != 0) begin
            $display("write burst at %0t starts at index %0d, not a tile start", $time, idx);
            flag_error();
        end
        if (idx >= exp_count) begin
            $display("extra C write at %0t to index %0d, only %0d words expected",
                     $time, idx, exp_count);
            flag_error();
        end else if (seen[idx]) begin
            $display("extra C write at %0t, index %0d written twice", $time, idx);
            flag_error();
        end else begin
            seen[idx] = 1'b1;
            words++;
            if (c_wr.data !== exp_words[idx]) begin
                $display("mismatch at %0t: test %0d index %0d got %h expected %h",
                         $time, test_num, idx, c_wr.data, exp_words[idx]);
                flag_error();
            end
        end
    endtask

    // Operand reads stay inside the A and B images of the current job
    task automatic check_reads();
        if (int'(a_index) >= (int'(dims.m) / 4) * int'(dims.k)) begin
            $display("A read index %0d at %0t lies outside the A matrix", a_index, $time);
            flag_error();
        end
        if (int'(b_index) >= (int'(dims.n) / 4) * int'(dims.k)) begin
            $display("B read index %0d at %0t lies outside the B matrix", b_index, $time);
            flag_error();
        end
    endtask

    task automatic close_test();
        if (words != exp_count) begin
            $display("test %0d: %0d expected C writes never happened",
                     test_num, exp_count - words);
            flag_error();
        end
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %0d: %0d words checked, passed", test_num, words);
        end else begin
            tests_failed++;
            $display("test %0d: %0d words seen, %0d errors, failed", test_num, words, test_errs);
        end
        test_errs = 0;
        words     = 0;
        for (int i = 0; i < MAX_C; i++)
            seen[i] = 1'b0;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            busy_q     = 1'b0;
            in_valid_q = 1'b0;
            run_len    = 0;
        end else begin
            // A run may only start from an accepted in_valid
            if (busy && !busy_q && !in_valid_q) begin
                $display("busy went high at %0t with no in_valid before it", $time);
                flag_error();
            end
            if (busy)
                check_reads();
            if (c_wr.wr_en) begin
                check_write();
                run_len++;
            end else if (run_len != 0) begin
                if (run_len != 4) begin
                    $display("write burst ending at %0t lasted %0d cycles instead of 4",
                             $time, run_len);
                    flag_error();
                end
                run_len = 0;
            end
            if (test_end)
                close_test();
            busy_q     = busy;
            in_valid_q = in_valid;
        end
    end

endmodule

//--- verification/tpu_tb.sv
`timescale 1ns/1ps
`include "tpu_defines.svh"

module tpu_tb;
    import tpu_data_pkg::*;
    import tpu_ctrl_pkg::*;

    localparam int NUM_TESTS = 7;
    localparam int MEM_WORDS = 4096;
    localparam int MAX_C     = 1024;

    typedef enum logic [1:0] {
        FILL_RANDOM,
        FILL_ONES,
        FILL_MAX
    } fill_mode_t;

    typedef struct packed {
        mat_dims_t  dims;
        fill_mode_t mode;
    } test_vec_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    mat_dims_t   dims;
    logic        busy;
    rd_req_t     a_index;
    rd_req_t     b_index;
    lane_vec_t   a_rdata;
    lane_vec_t   b_rdata;
    c_wr_t       c_wr;
    rd_req_t     a_idx_q;
    rd_req_t     b_idx_q;
    lane_vec_t   a_mem [MEM_WORDS];
    lane_vec_t   b_mem [MEM_WORDS];
    result_row_t exp_words [MAX_C];
    int          exp_count;
    int          test_num;
    logic        test_end;
    logic        timed_out;
    int          error_count;
    int          tests_passed;
    int          tests_failed;
    test_vec_t   tests [NUM_TESTS];
    operand_t    a_mat [64][255];
    operand_t    b_mat [255][64];

    tpu_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .dims     (dims),
        .busy     (busy),
        .a_index  (a_index),
        .a_rdata  (a_rdata),
        .b_index  (b_index),
        .b_rdata  (b_rdata),
        .c_wr     (c_wr)
    );

    tpu_checker #(.MAX_C(MAX_C)) chk0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .busy         (busy),
        .dims         (dims),
        .a_index      (a_index),
        .b_index      (b_index),
        .c_wr         (c_wr),
        .exp_words    (exp_words),
        .exp_count    (exp_count),
        .test_num     (test_num),
        .test_end     (test_end),
        .error_count  (error_count),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // A and B memories, index taken one cycle, data out the next
    initial begin
        a_rdata = '0;
        b_rdata = '0;
        a_idx_q = '0;
        b_idx_q = '0;
        forever begin
            @(negedge clk);
            a_rdata = (a_idx_q < 16'(MEM_WORDS)) ? a_mem[a_idx_q] : '0;
            b_rdata = (b_idx_q < 16'(MEM_WORDS)) ? b_mem[b_idx_q] : '0;
            a_idx_q = a_index;
            b_idx_q = b_index;
        end
    end

    function automatic test_vec_t make_test(input int k, input int m, input int n,
                                            input fill_mode_t mode);
        test_vec_t tv;
        tv.dims.k = 8'(k);
        tv.dims.m = 8'(m);
        tv.dims.n = 8'(n);
        tv.mode   = mode;
        return tv;
    endfunction

    function automatic operand_t pick_operand(input fill_mode_t mode);
        case (mode)
            FILL_ONES: return 8'd1;
            FILL_MAX:  return 8'hff;
            default:   return operand_t'($urandom);
        endcase
    endfunction

    // ------------------------------------------------
    // Operand matrices and memory images
    // ------------------------------------------------
    task automatic load_memories(input mat_dims_t d, input fill_mode_t mode);
        for (int i = 0; i < int'(d.m); i++)
            for (int j = 0; j < int'(d.k); j++)
                a_mat[i][j] = pick_operand(mode);
        for (int j = 0; j < int'(d.k); j++)
            for (int c = 0; c < int'(d.n); c++)
                b_mat[j][c] = pick_operand(mode);
        // Word mb*K+k carries one column slice of a row block
        for (int mb = 0; mb < int'(d.m) / 4; mb++)
            for (int j = 0; j < int'(d.k); j++)
                for (int r = 0; r < 4; r++)
                    a_mem[mb * int'(d.k) + j][r] = a_mat[4 * mb + r][j];
        for (int nb = 0; nb < int'(d.n) / 4; nb++)
            for (int j = 0; j < int'(d.k); j++)
                for (int c = 0; c < 4; c++)
                    b_mem[nb * int'(d.k) + j][c] = b_mat[j][4 * nb + c];
    endtask

    task automatic build_expected(input mat_dims_t d);
        acc_t sum;
        int   t;
        for (int nb = 0; nb < int'(d.n) / 4; nb++) begin
            for (int mb = 0; mb < int'(d.m) / 4; mb++) begin
                t = nb * (int'(d.m) / 4) + mb;
                for (int r = 0; r < 4; r++) begin
                    for (int c = 0; c < 4; c++) begin
                        sum = '0;
                        for (int j = 0; j < int'(d.k); j++)
                            sum += acc_t'(a_mat[4 * mb + r][j]) * acc_t'(b_mat[j][4 * nb + c]);
                        exp_words[4 * t + r][c] = sum;
                    end
                end
            end
        end
        exp_count = int'(d.m) * int'(d.n) / 4;
    endtask

    task automatic run_test(input int idx);
        test_vec_t tv;
        int        limit;
        int        cycles;
        tv = tests[idx];
        load_memories(tv.dims, tv.mode);
        build_expected(tv.dims);
        test_num = idx;
        @(negedge clk);
        dims     = tv.dims;
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        cycles   = 0;
        while (!busy && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!busy) begin
            $display("test %0d: busy never went high after in_valid", idx);
            timed_out = 1'b1;
            return;
        end
        // One tile is K+8 cycles
        limit  = (int'(tv.dims.m) / 4) * (int'(tv.dims.n) / 4) * (int'(tv.dims.k) + 8) + 50;
        cycles = 0;
        while (busy && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("test %0d: busy still high after %0d cycles", idx, limit);
            timed_out = 1'b1;
            return;
        end
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        dims      = '0;
        test_end  = 1'b0;
        test_num  = 0;
        exp_count = 0;
        timed_out = 1'b0;
        void'($urandom(32'hfe45_831f));
        tests[0] = make_test(1, 4, 4, FILL_RANDOM);
        tests[1] = make_test(255, 4, 4, FILL_MAX);
        tests[2] = make_test(7, 8, 12, FILL_RANDOM);
        tests[3] = make_test(3, 4, 8, FILL_ONES);
        tests[4] = make_test(255, 8, 4, FILL_MAX);
        tests[5] = make_test(16, 12, 8, FILL_RANDOM);
        tests[6] = make_test(20, 64, 64, FILL_RANDOM);
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        // Idle gap, busy has to stay low here
        repeat (5) @(negedge clk);
        for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
            run_test(i);
        end
        repeat (2) @(negedge clk);
        $display("%0d tests passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (timed_out || error_count != 0 || tests_failed != 0) begin
            $display("Something failed");
        end else begin
            $display("Everything OK");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
hdl/tpu_data_pkg.sv
hdl/tpu_ctrl_pkg.sv
hdl/tpu_pe.sv
hdl/tpu_skew_buffer.sv
hdl/tpu_pe_array.sv
hdl/tpu_controller.sv
hdl/tpu_top.sv
verification/tpu_checker.sv
verification/tpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the systolic multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tpu_tb -o tpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1
